//--- verilog/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath width
`define EXEC_XLEN 32

// architectural register count, x0 hardwired to zero
`define EXEC_NREGS 32

// register index width, log2 of EXEC_NREGS
`define EXEC_RADDR_W 5

`endif

//--- verilog/exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

  // register index
  typedef logic [`EXEC_RADDR_W-1:0] reg_addr_t;

  // integer alu opcodes
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,  // signed compare
    ALU_SLTU  = 4'd9,  // unsigned compare
    ALU_PASSB = 4'd10  // b straight through, as for lui
  } alu_op_t;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/1ps

`include "exec_settings.svh"

module register_file (
  input  logic                   clk,
  input  logic                   rst_n,
  // lane 0 read ports
  input  exec_pkg::reg_addr_t    raddr0_1,
  input  exec_pkg::reg_addr_t    raddr0_2,
  output logic [`EXEC_XLEN-1:0]  rdata0_1,
  output logic [`EXEC_XLEN-1:0]  rdata0_2,
  // lane 1 read ports
  input  exec_pkg::reg_addr_t    raddr1_1,
  input  exec_pkg::reg_addr_t    raddr1_2,
  output logic [`EXEC_XLEN-1:0]  rdata1_1,
  output logic [`EXEC_XLEN-1:0]  rdata1_2,
  // write ports, one per lane
  input  logic                   wren0,
  input  exec_pkg::reg_addr_t    waddr0,
  input  logic [`EXEC_XLEN-1:0]  wdata0,
  input  logic                   wren1,
  input  exec_pkg::reg_addr_t    waddr1,
  input  logic [`EXEC_XLEN-1:0]  wdata1
);

  logic [`EXEC_XLEN-1:0] regs [0:`EXEC_NREGS-1];

  // x0 reads as zero whatever the array holds
  always_comb begin
    rdata0_1 = (raddr0_1 == '0) ? '0 : regs[raddr0_1];
    rdata0_2 = (raddr0_2 == '0) ? '0 : regs[raddr0_2];
    rdata1_1 = (raddr1_1 == '0) ? '0 : regs[raddr1_1];
    rdata1_2 = (raddr1_2 == '0) ? '0 : regs[raddr1_2];
  end

  always_ff @(posedge clk) begin
    if (wren0) begin
      regs[waddr0] <= wdata0;
    end
    if (wren1) begin
      regs[waddr1] <= wdata1; // younger lane wins on a collision
    end
  end

  // lanes must filter rd == 0 before writeback
  a_no_x0_write0 : assert property (
    @(posedge clk) disable iff (!rst_n)
    wren0 |-> (waddr0 != '0)
  ) else $error("register_file: write to x0 on port 0");

  a_no_x0_write1 : assert property (
    @(posedge clk) disable iff (!rst_n)
    wren1 |-> (waddr1 != '0)
  ) else $error("register_file: write to x0 on port 1");

endmodule

//--- verilog/forwarding.sv
`timescale 1ns/1ps

`include "exec_settings.svh"

module forwarding (
  // lane 0 register reads
  input  logic                   rden0_1,
  input  logic                   rden0_2,
  input  exec_pkg::reg_addr_t    raddr0_1,
  input  exec_pkg::reg_addr_t    raddr0_2,
  input  logic [`EXEC_XLEN-1:0]  rdata0_1,
  input  logic [`EXEC_XLEN-1:0]  rdata0_2,
  // lane 1 register reads
  input  logic                   rden1_1,
  input  logic                   rden1_2,
  input  exec_pkg::reg_addr_t    raddr1_1,
  input  exec_pkg::reg_addr_t    raddr1_2,
  input  logic [`EXEC_XLEN-1:0]  rdata1_1,
  input  logic [`EXEC_XLEN-1:0]  rdata1_2,
  // in-flight results, memory stage
  input  logic                   mem0_wren,
  input  exec_pkg::reg_addr_t    mem0_waddr,
  input  logic [`EXEC_XLEN-1:0]  mem0_wdata,
  input  logic                   mem1_wren,
  input  exec_pkg::reg_addr_t    mem1_waddr,
  input  logic [`EXEC_XLEN-1:0]  mem1_wdata,
  // in-flight results, writeback stage
  input  logic                   wb0_wren,
  input  exec_pkg::reg_addr_t    wb0_waddr,
  input  logic [`EXEC_XLEN-1:0]  wb0_wdata,
  input  logic                   wb1_wren,
  input  exec_pkg::reg_addr_t    wb1_waddr,
  input  logic [`EXEC_XLEN-1:0]  wb1_wdata,
  // bypassed operands
  output logic [`EXEC_XLEN-1:0]  opa0,
  output logic [`EXEC_XLEN-1:0]  opb_reg0,
  output logic [`EXEC_XLEN-1:0]  opa1,
  output logic [`EXEC_XLEN-1:0]  opb_reg1
);

  // youngest matching producer wins, later checks override earlier ones
  function automatic logic [`EXEC_XLEN-1:0] bypass(
    input logic                  rden,
    input exec_pkg::reg_addr_t   raddr,
    input logic [`EXEC_XLEN-1:0] rdata
  );
    logic [`EXEC_XLEN-1:0] res;
    res = '0;
    if (rden) begin
      res = rdata;
      if (wb0_wren && (raddr == wb0_waddr)) begin
        res = wb0_wdata;
      end
      if (wb1_wren && (raddr == wb1_waddr)) begin
        res = wb1_wdata;
      end
      if (mem0_wren && (raddr == mem0_waddr)) begin
        res = mem0_wdata;
      end
      if (mem1_wren && (raddr == mem1_waddr)) begin
        res = mem1_wdata; // lane 1 memory stage is the youngest
      end
    end
    return res;
  endfunction

  always_comb begin
    opa0     = bypass(rden0_1, raddr0_1, rdata0_1);
    opb_reg0 = bypass(rden0_2, raddr0_2, rdata0_2);
    opa1     = bypass(rden1_1, raddr1_1, rdata1_1);
    opb_reg1 = bypass(rden1_2, raddr1_2, rdata1_2);

    // unused operand slots must not leak stale data into the lanes
    assert (rden0_1 || (opa0 == '0))
      else $error("forwarding: opa0 nonzero with read disabled");
    assert (rden0_2 || (opb_reg0 == '0))
      else $error("forwarding: opb_reg0 nonzero with read disabled");
    assert (rden1_1 || (opa1 == '0))
      else $error("forwarding: opa1 nonzero with read disabled");
    assert (rden1_2 || (opb_reg1 == '0))
      else $error("forwarding: opb_reg1 nonzero with read disabled");
  end

endmodule

//--- verilog/alu_lane.sv
`timescale 1ns/1ps

`include "exec_settings.svh"

module alu_lane (
  input  logic                   clk,
  input  logic                   rst_n,
  // issue slot
  input  logic                   valid,
  input  exec_pkg::alu_op_t      op,
  input  exec_pkg::reg_addr_t    rd,
  input  logic                   use_imm,
  input  logic [`EXEC_XLEN-1:0]  imm,
  input  logic [`EXEC_XLEN-1:0]  opa,
  input  logic [`EXEC_XLEN-1:0]  opb_reg,
  // memory stage outputs to forwarding
  output logic                   mem_wren,
  output exec_pkg::reg_addr_t    mem_waddr,
  output logic [`EXEC_XLEN-1:0]  mem_wdata,
  // writeback stage outputs to forwarding and register file
  output logic                   wb_wren,
  output exec_pkg::reg_addr_t    wb_waddr,
  output logic [`EXEC_XLEN-1:0]  wb_wdata,
  // retire report
  output logic                   commit_valid,
  output exec_pkg::reg_addr_t    commit_rd,
  output logic [`EXEC_XLEN-1:0]  commit_data
);

  logic [`EXEC_XLEN-1:0] opb;
  logic [`EXEC_XLEN-1:0] result;
  logic [4:0]            shamt;
  logic                  mem_valid;
  logic                  wb_valid;

  assign opb   = use_imm ? imm : opb_reg;
  assign shamt = opb[4:0];

  always_comb begin
    case (op)
      exec_pkg::ALU_ADD:   result = opa + opb;
      exec_pkg::ALU_SUB:   result = opa - opb;
      exec_pkg::ALU_AND:   result = opa & opb;
      exec_pkg::ALU_OR:    result = opa | opb;
      exec_pkg::ALU_XOR:   result = opa ^ opb;
      exec_pkg::ALU_SLL:   result = opa << shamt;
      exec_pkg::ALU_SRL:   result = opa >> shamt;
      exec_pkg::ALU_SRA:   result = $signed(opa) >>> shamt;
      exec_pkg::ALU_SLT:   result = {{(`EXEC_XLEN-1){1'b0}}, ($signed(opa) < $signed(opb))};
      exec_pkg::ALU_SLTU:  result = {{(`EXEC_XLEN-1){1'b0}}, (opa < opb)};
      exec_pkg::ALU_PASSB: result = opb;
      default:             result = '0;
    endcase
  end

  // stage valids
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      mem_valid <= valid;
      wb_valid  <= mem_valid;
    end
  end

  // payload only moves with a valid instruction
  always_ff @(posedge clk) begin
    if (valid) begin
      mem_waddr <= rd;
      mem_wdata <= result;
    end
    if (mem_valid) begin
      wb_waddr <= mem_waddr;
      wb_wdata <= mem_wdata; // memory stage carries the result only
    end
  end

  assign mem_wren = mem_valid && (mem_waddr != '0);
  assign wb_wren  = wb_valid && (wb_waddr != '0);

  assign commit_valid = wb_valid;
  assign commit_rd    = wb_waddr;
  assign commit_data  = wb_wdata;

  a_wren_commits : assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_wren |-> commit_valid
  ) else $error("alu_lane: writeback without commit");

  a_legal_op : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid |-> (op inside {exec_pkg::ALU_ADD, exec_pkg::ALU_SUB, exec_pkg::ALU_AND,
                          exec_pkg::ALU_OR, exec_pkg::ALU_XOR, exec_pkg::ALU_SLL,
                          exec_pkg::ALU_SRL, exec_pkg::ALU_SRA, exec_pkg::ALU_SLT,
                          exec_pkg::ALU_SLTU, exec_pkg::ALU_PASSB})
  ) else $error("alu_lane: illegal opcode issued");

endmodule

//--- verilog/exec_top.sv
`timescale 1ns/1ps

`include "exec_settings.svh"

module exec_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // lane 0 issue
  input  logic                   issue0_valid,
  input  exec_pkg::alu_op_t      issue0_op,
  input  exec_pkg::reg_addr_t    issue0_rs1,
  input  exec_pkg::reg_addr_t    issue0_rs2,
  input  exec_pkg::reg_addr_t    issue0_rd,
  input  logic                   issue0_use_imm,
  input  logic [`EXEC_XLEN-1:0]  issue0_imm,
  // lane 1 issue
  input  logic                   issue1_valid,
  input  exec_pkg::alu_op_t      issue1_op,
  input  exec_pkg::reg_addr_t    issue1_rs1,
  input  exec_pkg::reg_addr_t    issue1_rs2,
  input  exec_pkg::reg_addr_t    issue1_rd,
  input  logic                   issue1_use_imm,
  input  logic [`EXEC_XLEN-1:0]  issue1_imm,
  // commits
  output logic                   commit0_valid,
  output exec_pkg::reg_addr_t    commit0_rd,
  output logic [`EXEC_XLEN-1:0]  commit0_data,
  output logic                   commit1_valid,
  output exec_pkg::reg_addr_t    commit1_rd,
  output logic [`EXEC_XLEN-1:0]  commit1_data
);

  logic                  rden0_1;
  logic                  rden0_2;
  logic                  rden1_1;
  logic                  rden1_2;
  logic [`EXEC_XLEN-1:0] rdata0_1;
  logic [`EXEC_XLEN-1:0] rdata0_2;
  logic [`EXEC_XLEN-1:0] rdata1_1;
  logic [`EXEC_XLEN-1:0] rdata1_2;
  logic [`EXEC_XLEN-1:0] opa0;
  logic [`EXEC_XLEN-1:0] opb_reg0;
  logic [`EXEC_XLEN-1:0] opa1;
  logic [`EXEC_XLEN-1:0] opb_reg1;

  logic                  mem0_wren;
  exec_pkg::reg_addr_t   mem0_waddr;
  logic [`EXEC_XLEN-1:0] mem0_wdata;
  logic                  wb0_wren;
  exec_pkg::reg_addr_t   wb0_waddr;
  logic [`EXEC_XLEN-1:0] wb0_wdata;
  logic                  mem1_wren;
  exec_pkg::reg_addr_t   mem1_waddr;
  logic [`EXEC_XLEN-1:0] mem1_wdata;
  logic                  wb1_wren;
  exec_pkg::reg_addr_t   wb1_waddr;
  logic [`EXEC_XLEN-1:0] wb1_wdata;

  assign rden0_1 = issue0_valid;
  assign rden0_2 = issue0_valid && !issue0_use_imm; // immediate replaces rs2
  assign rden1_1 = issue1_valid;
  assign rden1_2 = issue1_valid && !issue1_use_imm;

  register_file u_regs (
    .clk(clk), .rst_n(rst_n),
    .raddr0_1(issue0_rs1), .raddr0_2(issue0_rs2),
    .rdata0_1(rdata0_1), .rdata0_2(rdata0_2),
    .raddr1_1(issue1_rs1), .raddr1_2(issue1_rs2),
    .rdata1_1(rdata1_1), .rdata1_2(rdata1_2),
    .wren0(wb0_wren), .waddr0(wb0_waddr), .wdata0(wb0_wdata),
    .wren1(wb1_wren), .waddr1(wb1_waddr), .wdata1(wb1_wdata)
  );

  // no bypass inside an issue pair, lane 1 sees the older value
  forwarding u_fwd (
    .rden0_1(rden0_1), .rden0_2(rden0_2),
    .raddr0_1(issue0_rs1), .raddr0_2(issue0_rs2),
    .rdata0_1(rdata0_1), .rdata0_2(rdata0_2),
    .rden1_1(rden1_1), .rden1_2(rden1_2),
    .raddr1_1(issue1_rs1), .raddr1_2(issue1_rs2),
    .rdata1_1(rdata1_1), .rdata1_2(rdata1_2),
    .mem0_wren(mem0_wren), .mem0_waddr(mem0_waddr), .mem0_wdata(mem0_wdata),
    .mem1_wren(mem1_wren), .mem1_waddr(mem1_waddr), .mem1_wdata(mem1_wdata),
    .wb0_wren(wb0_wren), .wb0_waddr(wb0_waddr), .wb0_wdata(wb0_wdata),
    .wb1_wren(wb1_wren), .wb1_waddr(wb1_waddr), .wb1_wdata(wb1_wdata),
    .opa0(opa0), .opb_reg0(opb_reg0),
    .opa1(opa1), .opb_reg1(opb_reg1)
  );

  alu_lane u_lane0 (
    .clk(clk), .rst_n(rst_n),
    .valid(issue0_valid), .op(issue0_op), .rd(issue0_rd),
    .use_imm(issue0_use_imm), .imm(issue0_imm),
    .opa(opa0), .opb_reg(opb_reg0),
    .mem_wren(mem0_wren), .mem_waddr(mem0_waddr), .mem_wdata(mem0_wdata),
    .wb_wren(wb0_wren), .wb_waddr(wb0_waddr), .wb_wdata(wb0_wdata),
    .commit_valid(commit0_valid), .commit_rd(commit0_rd), .commit_data(commit0_data)
  );

  alu_lane u_lane1 (
    .clk(clk), .rst_n(rst_n),
    .valid(issue1_valid), .op(issue1_op), .rd(issue1_rd),
    .use_imm(issue1_use_imm), .imm(issue1_imm),
    .opa(opa1), .opb_reg(opb_reg1),
    .mem_wren(mem1_wren), .mem_waddr(mem1_waddr), .mem_wdata(mem1_wdata),
    .wb_wren(wb1_wren), .wb_waddr(wb1_waddr), .wb_wdata(wb1_wdata),
    .commit_valid(commit1_valid), .commit_rd(commit1_rd), .commit_data(commit1_data)
  );

endmodule

//--- tests/tb_exec_top.sv
`timescale 1ns/1ps

`include "exec_settings.svh"

module tb_exec_top;

  localparam int XLEN        = `EXEC_XLEN;
  localparam int CLK_PERIOD  = 20;
  localparam int NUM_ENTRIES = 200;
  localparam int NUM_TESTS   = 7;
  localparam int RUN_LIMIT   = NUM_ENTRIES + 10; // clock periods before the watchdog fires

  typedef struct {
    logic                valid;
    exec_pkg::alu_op_t   op;
    exec_pkg::reg_addr_t rs1;
    exec_pkg::reg_addr_t rs2;
    exec_pkg::reg_addr_t rd;
    logic                use_imm;
    logic [XLEN-1:0]     imm;
  } slot_t;

  typedef struct {
    logic                valid;
    exec_pkg::reg_addr_t rd;
    logic [XLEN-1:0]     data;
  } commit_t;

  logic                clk;
  logic                rst_n;
  logic                issue0_valid;
  exec_pkg::alu_op_t   issue0_op;
  exec_pkg::reg_addr_t issue0_rs1;
  exec_pkg::reg_addr_t issue0_rs2;
  exec_pkg::reg_addr_t issue0_rd;
  logic                issue0_use_imm;
  logic [XLEN-1:0]     issue0_imm;
  logic                issue1_valid;
  exec_pkg::alu_op_t   issue1_op;
  exec_pkg::reg_addr_t issue1_rs1;
  exec_pkg::reg_addr_t issue1_rs2;
  exec_pkg::reg_addr_t issue1_rd;
  logic                issue1_use_imm;
  logic [XLEN-1:0]     issue1_imm;
  logic                commit0_valid;
  exec_pkg::reg_addr_t commit0_rd;
  logic [XLEN-1:0]     commit0_data;
  logic                commit1_valid;
  exec_pkg::reg_addr_t commit1_rd;
  logic [XLEN-1:0]     commit1_data;

  slot_t           stim [0:NUM_ENTRIES-1][0:1];
  int              test_of [0:NUM_ENTRIES-1];
  string           test_names [0:NUM_TESTS-1] = '{"init", "alu_ops", "lane_dep",
                                                  "cross_lane", "same_pair", "x0_bubble",
                                                  "random"};
  int              test_checks [0:NUM_TESTS-1];
  int              test_errs [0:NUM_TESTS-1];
  logic [XLEN-1:0] model_regs [0:`EXEC_NREGS-1]; // architectural state
  commit_t         exp_q0 [$];
  commit_t         exp_q1 [$];
  slot_t           idle_slot;
  int              fill_idx;
  int              cur_test;

  exec_top UUT (
    .clk(clk), .rst_n(rst_n),
    .issue0_valid(issue0_valid), .issue0_op(issue0_op),
    .issue0_rs1(issue0_rs1), .issue0_rs2(issue0_rs2), .issue0_rd(issue0_rd),
    .issue0_use_imm(issue0_use_imm), .issue0_imm(issue0_imm),
    .issue1_valid(issue1_valid), .issue1_op(issue1_op),
    .issue1_rs1(issue1_rs1), .issue1_rs2(issue1_rs2), .issue1_rd(issue1_rd),
    .issue1_use_imm(issue1_use_imm), .issue1_imm(issue1_imm),
    .commit0_valid(commit0_valid), .commit0_rd(commit0_rd), .commit0_data(commit0_data),
    .commit1_valid(commit1_valid), .commit1_rd(commit1_rd), .commit1_data(commit1_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [XLEN-1:0] expected_result(input exec_pkg::alu_op_t op,
                                                      input logic [XLEN-1:0] a,
                                                      input logic [XLEN-1:0] b);
    logic [4:0]      sh;
    logic [XLEN-1:0] fill;
    sh   = b[4:0];
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0; // sign bits entering from the top
    case (op)
      exec_pkg::ALU_ADD:   return a + b;
      exec_pkg::ALU_SUB:   return a - b;
      exec_pkg::ALU_AND:   return a & b;
      exec_pkg::ALU_OR:    return a | b;
      exec_pkg::ALU_XOR:   return a ^ b;
      exec_pkg::ALU_SLL:   return a << sh;
      exec_pkg::ALU_SRL:   return a >> sh;
      exec_pkg::ALU_SRA:   return (a >> sh) | fill;
      // differing signs decide the signed compare by a alone
      exec_pkg::ALU_SLT:   return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
      exec_pkg::ALU_SLTU:  return XLEN'(a < b);
      exec_pkg::ALU_PASSB: return b;
      default:             return '0;
    endcase
  endfunction

  task automatic put_slot(input int lane, input exec_pkg::alu_op_t op, input int rs1,
                          input int rs2, input int rd, input int use_imm, input int imm);
    stim[fill_idx][lane].valid   = 1'b1;
    stim[fill_idx][lane].op      = op;
    stim[fill_idx][lane].rs1     = exec_pkg::reg_addr_t'(rs1);
    stim[fill_idx][lane].rs2     = exec_pkg::reg_addr_t'(rs2);
    stim[fill_idx][lane].rd      = exec_pkg::reg_addr_t'(rd);
    stim[fill_idx][lane].use_imm = (use_imm != 0);
    stim[fill_idx][lane].imm     = imm;
  endtask

  task automatic close_entry();
    test_of[fill_idx] = cur_test;
    fill_idx++;
  endtask

  task automatic build_table();
    int k;
    int l;
    for (k = 0; k < NUM_ENTRIES; k++) begin
      for (l = 0; l < 2; l++) begin
        stim[k][l].valid   = 1'b0; // junk fields behind a bubble
        stim[k][l].op      = exec_pkg::ALU_ADD;
        stim[k][l].rs1     = exec_pkg::reg_addr_t'($urandom);
        stim[k][l].rs2     = exec_pkg::reg_addr_t'($urandom);
        stim[k][l].rd      = exec_pkg::reg_addr_t'($urandom);
        stim[k][l].use_imm = 1'b0;
        stim[k][l].imm     = $urandom;
      end
    end
    fill_idx = 0;
    cur_test = 0;
    for (k = 1; k < `EXEC_NREGS; k += 2) begin
      put_slot(0, exec_pkg::ALU_PASSB, 0, 0, k, 1, 0);
      if (k + 1 < `EXEC_NREGS) put_slot(1, exec_pkg::ALU_PASSB, 0, 0, k + 1, 1, 0);
      close_entry();
    end
    cur_test = 1;
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 1, 1, 32'h8000_0010);
    put_slot(1, exec_pkg::ALU_PASSB, 0, 0, 2, 1, 32'h0000_0024);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 1, 2, 3, 0, 0);
    put_slot(1, exec_pkg::ALU_SUB, 2, 1, 4, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_AND, 1, 2, 5, 0, 0);
    put_slot(1, exec_pkg::ALU_OR, 1, 2, 6, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_XOR, 1, 2, 7, 0, 0);
    put_slot(1, exec_pkg::ALU_SLL, 1, 2, 8, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_SRL, 1, 2, 9, 0, 0);
    put_slot(1, exec_pkg::ALU_SRA, 1, 2, 10, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_SLT, 1, 2, 11, 0, 0);
    put_slot(1, exec_pkg::ALU_SLTU, 1, 2, 12, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_SLT, 2, 0, 13, 1, -1);
    put_slot(1, exec_pkg::ALU_SLTU, 2, 0, 14, 1, -1);
    close_entry();
    put_slot(0, exec_pkg::ALU_SRA, 1, 0, 15, 1, 31);
    put_slot(1, exec_pkg::ALU_SLL, 2, 0, 16, 1, 33); // only 5 shift bits count
    close_entry();
    cur_test = 2;
    put_slot(0, exec_pkg::ALU_ADD, 0, 0, 5, 1, 100);
    put_slot(1, exec_pkg::ALU_PASSB, 0, 0, 9, 1, 7);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 5, 0, 5, 1, 1);
    put_slot(1, exec_pkg::ALU_ADD, 9, 0, 10, 1, 1);
    close_entry();
    put_slot(0, exec_pkg::ALU_SUB, 5, 0, 6, 1, 3);
    put_slot(1, exec_pkg::ALU_XOR, 10, 9, 11, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 5, 6, 7, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_OR, 5, 7, 8, 0, 0);
    put_slot(1, exec_pkg::ALU_ADD, 11, 10, 12, 0, 0);
    close_entry();
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 8, 6, 13, 0, 0);
    put_slot(1, exec_pkg::ALU_SUB, 12, 7, 14, 0, 0);
    close_entry();
    cur_test = 3;
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 15, 1, 32'h111);
    put_slot(1, exec_pkg::ALU_PASSB, 0, 0, 16, 1, 32'h222);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 16, 0, 17, 1, 1);
    put_slot(1, exec_pkg::ALU_ADD, 15, 0, 18, 1, 2);
    close_entry();
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 19, 1, 32'hA0);
    put_slot(1, exec_pkg::ALU_PASSB, 0, 0, 19, 1, 32'hB0);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 19, 0, 21, 1, 0);
    put_slot(1, exec_pkg::ALU_PASSB, 0, 0, 19, 1, 32'hB1);
    close_entry();
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 19, 1, 32'hC0);
    put_slot(1, exec_pkg::ALU_ADD, 19, 17, 22, 0, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 19, 0, 23, 1, 0);
    put_slot(1, exec_pkg::ALU_ADD, 19, 18, 24, 0, 0);
    close_entry();
    cur_test = 4;
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 25, 1, 32'h55);
    close_entry();
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 25, 1, 32'h66);
    put_slot(1, exec_pkg::ALU_ADD, 25, 0, 26, 1, 0);
    close_entry();
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 27, 1, 32'h77);
    put_slot(1, exec_pkg::ALU_PASSB, 0, 0, 27, 1, 32'h88);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 27, 0, 28, 1, 0);
    close_entry();
    put_slot(1, exec_pkg::ALU_ADD, 27, 0, 31, 1, 1);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 27, 0, 29, 1, 0);
    put_slot(1, exec_pkg::ALU_SUB, 27, 25, 30, 0, 0);
    close_entry();
    cur_test = 5;
    put_slot(0, exec_pkg::ALU_PASSB, 0, 0, 0, 1, 32'h1234);
    put_slot(1, exec_pkg::ALU_ADD, 1, 0, 0, 1, 5);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 0, 0, 31, 1, 0);
    put_slot(1, exec_pkg::ALU_OR, 0, 0, 30, 0, 0);
    close_entry();
    put_slot(1, exec_pkg::ALU_ADD, 0, 0, 1, 1, 9);
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 0, 0, 2, 1, 3);
    close_entry();
    close_entry();
    put_slot(0, exec_pkg::ALU_ADD, 1, 2, 3, 0, 0);
    put_slot(1, exec_pkg::ALU_SUB, 1, 2, 0, 0, 0);
    close_entry();
    cur_test = 6;
    // x0..x7 only so producers and consumers collide often
    for (k = fill_idx; k < NUM_ENTRIES; k++) begin
      test_of[k] = cur_test;
      for (l = 0; l < 2; l++) begin
        stim[k][l].valid   = ($urandom % 8) != 0;
        stim[k][l].op      = exec_pkg::alu_op_t'($urandom % 11);
        stim[k][l].rs1     = exec_pkg::reg_addr_t'($urandom % 8);
        stim[k][l].rs2     = exec_pkg::reg_addr_t'($urandom % 8);
        stim[k][l].rd      = exec_pkg::reg_addr_t'($urandom % 8);
        stim[k][l].use_imm = ($urandom % 3) == 0;
        stim[k][l].imm     = ($urandom % 2) != 0 ? $urandom : $urandom % 40;
      end
    end
    for (k = 0; k < `EXEC_NREGS; k++) begin
      model_regs[k] = '0;
    end
  endtask

  task automatic drive_pair(input slot_t s0, input slot_t s1);
    issue0_valid   <= s0.valid;
    issue0_op      <= s0.op;
    issue0_rs1     <= s0.rs1;
    issue0_rs2     <= s0.rs2;
    issue0_rd      <= s0.rd;
    issue0_use_imm <= s0.use_imm;
    issue0_imm     <= s0.imm;
    issue1_valid   <= s1.valid;
    issue1_op      <= s1.op;
    issue1_rs1     <= s1.rs1;
    issue1_rs2     <= s1.rs2;
    issue1_rd      <= s1.rd;
    issue1_use_imm <= s1.use_imm;
    issue1_imm     <= s1.imm;
  endtask

  task automatic predict_pair(input int k);
    commit_t         c [0:1];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int              l;
    for (l = 0; l < 2; l++) begin
      a = model_regs[stim[k][l].rs1];
      b = stim[k][l].use_imm ? stim[k][l].imm : model_regs[stim[k][l].rs2];
      c[l].valid = stim[k][l].valid;
      c[l].rd    = stim[k][l].rd;
      c[l].data  = expected_result(stim[k][l].op, a, b);
    end
    // both lanes read before either writes and lane 1 lands last
    for (l = 0; l < 2; l++) begin
      if (c[l].valid && c[l].rd != '0) model_regs[c[l].rd] = c[l].data;
    end
    exp_q0.push_back(c[0]);
    exp_q1.push_back(c[1]);
  endtask

  task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want, input int t);
    test_checks[t]++;
    assert (got === want) else begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, want);
      test_errs[t]++;
    end
  endtask

  task automatic check_commits(input int k);
    commit_t e0;
    commit_t e1;
    int      t;
    t  = test_of[k];
    e0 = exp_q0.pop_front();
    e1 = exp_q1.pop_front();
    compare_value("commit0_valid", XLEN'(commit0_valid), XLEN'(e0.valid), t);
    if (e0.valid) begin
      compare_value("commit0_rd", XLEN'(commit0_rd), XLEN'(e0.rd), t);
      compare_value("commit0_data", commit0_data, e0.data, t);
    end
    compare_value("commit1_valid", XLEN'(commit1_valid), XLEN'(e1.valid), t);
    if (e1.valid) begin
      compare_value("commit1_rd", XLEN'(commit1_rd), XLEN'(e1.rd), t);
      compare_value("commit1_data", commit1_data, e1.data, t);
    end
    if (k == NUM_ENTRIES - 1 || test_of[k + 1] != t) begin // last entry of this test
      $display("test %-10s %0d checks, %0d errors", test_names[t], test_checks[t],
               test_errs[t]);
    end
  endtask

  initial begin
    #(RUN_LIMIT * CLK_PERIOD);
    $display("timeout: run still busy after %0d clock periods", RUN_LIMIT);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int k;
    int total_checks;
    int total_errs;
    void'($urandom(32'h7b71_b8d2));
    clk   = 1'b0;
    rst_n = 1'b0;
    idle_slot = '{valid: 1'b0, op: exec_pkg::ALU_ADD, rs1: '0, rs2: '0, rd: '0,
                  use_imm: 1'b0, imm: '0};
    drive_pair(idle_slot, idle_slot);
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // commits of entry k show two edges after it is driven
    for (k = 0; k < NUM_ENTRIES + 2; k++) begin
      @(posedge clk);
      if (k < NUM_ENTRIES) begin
        drive_pair(stim[k][0], stim[k][1]);
        predict_pair(k);
      end else begin
        drive_pair(idle_slot, idle_slot);
      end
      @(negedge clk);
      if (k >= 2) check_commits(k - 2);
    end
    total_checks = 0;
    total_errs   = 0;
    for (k = 0; k < NUM_TESTS; k++) begin
      total_checks += test_checks[k];
      total_errs   += test_errs[k];
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- dual_issue_exec.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/register_file.sv
verilog/forwarding.sv
verilog/alu_lane.sv
verilog/exec_top.sv
tests/tb_exec_top.sv

//--- Makefile
# Verilator build and run of the dual_issue_exec testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_exec_top, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f dual_issue_exec.f --top-module tb_exec_top \
		-Mdir obj_dir -o sim_exec
	./obj_dir/sim_exec > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "STATUS: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
